/* compile.f */
+incdir+common
common/nic_pkg.sv
common/rpc_channel_if.sv
csr/nic_csr.sv
rpc/rpc_flow_filter.sv
rpc/rpc_credit_fifo.sv
source/nic_counters.sv
source/nic_top.sv
dv/nic_checker.sv
dv/nic_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the NIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -f compile.f \
    --top-module nic_tb -Mdir obj_dir -o nic_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/nic_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

/* dv/nic_tb.sv */
// ========================================
// NIC testbench
// CSR readback, forwarding, filtering,
// back-pressure, counters and status
// ========================================

`timescale 1ns/1ns

`include "nic_config.svh"

module nic_tb;

    import nic_pkg::*;

    localparam logic [31:0] SEED = 32'hf1770136;
    localparam int FIFO_DEPTH = 1 << `NIC_RPC_FIFO_LDEPTH;
    localparam int EXP_SLOTS = 512;
    // 275 RPCs at up to 4 cycles each, plus CSR traffic and drains
    localparam int STIM_RPCS = 275;
    localparam int STIM_CYCLES = 4 * STIM_RPCS + 400;
    localparam int TIMEOUT_CYCLES = 20 * STIM_CYCLES;

    logic                        ccip_clk = 1'b0;
    logic                        reset;
    logic                        mmio_wr_valid;
    logic [`NIC_MMIO_ADDR_W-1:0] mmio_wr_addr;
    logic [63:0]                 mmio_wr_data;
    logic                        mmio_rd_valid;
    logic [`NIC_MMIO_ADDR_W-1:0] mmio_rd_addr;
    logic [8:0]                  mmio_rd_tid;
    logic                        mmio_rsp_valid;
    logic [8:0]                  mmio_rsp_tid;
    logic [63:0]                 mmio_rsp_data;
    logic                        rpc_in_valid;
    logic [`NIC_FLOW_ID_W-1:0]   rpc_in_flow_id;
    logic [`NIC_RPC_DATA_W-1:0]  rpc_in_data;
    logic [1:0]                  rpc_in_credit;
    logic                        net_tx_valid;
    logic [`NIC_FLOW_ID_W-1:0]   net_tx_flow_id;
    logic [`NIC_RPC_DATA_W-1:0]  net_tx_data;
    logic                        net_tx_credit = 1'b0;

    // Host and network models
    rpc_t        exp_mem [EXP_SLOTS];
    int          exp_wr = 0;
    int          exp_rd = 0;
    int          credits_used = 0;
    int          credits_back = 0;
    int          rx_count = 0;
    int          granted_pulses = 0;
    int          model_in = 0;
    int          model_drop = 0;
    int          cfg_num_flows = 0;
    bit          cfg_start = 1'b0;
    bit          model_error = 1'b0;
    logic        net_enable = 1'b1;
    int          err_csr = 0;
    int          err_egress = 0;

    always #4 ccip_clk = ~ccip_clk;

    nic_top dut_i (.*);

    // ========================================
    // Reference model
    // ========================================
    function automatic bit predict_admit(input logic [`NIC_FLOW_ID_W-1:0] flow_id,
                                         input int num_flows, input bit start);
        return start && (int'(flow_id) < num_flows);
    endfunction

    function automatic int host_credit_count();
        return `NIC_RPC_CREDITS + credits_back - credits_used;
    endfunction

    // Egress credits spent by the DUT and not yet returned
    function automatic int owed_net_credits();
        return rx_count - granted_pulses;
    endfunction

    // ========================================
    // Host side tasks
    // ========================================
    task automatic write_csr(input logic [15:0] addr, input logic [63:0] data);
        @(posedge ccip_clk);
        mmio_wr_valid <= 1'b1;
        mmio_wr_addr  <= addr;
        mmio_wr_data  <= data;
        @(posedge ccip_clk);
        mmio_wr_valid <= 1'b0;
        if (addr == NUM_FLOWS) begin
            cfg_num_flows = int'(data[`NIC_FLOW_ID_W:0]);
        end
        if (addr == START) begin
            cfg_start = data[0];
        end
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [63:0] expected,
                              input string what);
        logic [8:0] tid;
        tid = 9'($urandom);
        @(posedge ccip_clk);
        mmio_rd_valid <= 1'b1;
        mmio_rd_addr  <= addr;
        mmio_rd_tid   <= tid;
        @(negedge ccip_clk);
        if (mmio_rsp_valid) begin
            err_csr++;
            $display("Read response for %s came in the request cycle", what);
        end
        @(posedge ccip_clk);
        mmio_rd_valid <= 1'b0;
        @(negedge ccip_clk);
        if (!mmio_rsp_valid) begin
            err_csr++;
            $display("No read response one cycle after the read of %s", what);
        end else begin
            if (mmio_rsp_tid != tid) begin
                err_csr++;
                $display("ERR %0t mmio_rsp_tid got %h expected %h (%s)",
                         $time, mmio_rsp_tid, tid, what);
            end
            if (mmio_rsp_data != expected) begin
                err_csr++;
                $display("ERR %0t mmio_rsp_data got %h expected %h (%s)",
                         $time, mmio_rsp_data, expected, what);
            end
        end
    endtask

    task automatic drive_rpc(input logic [`NIC_FLOW_ID_W-1:0] flow_id,
                             input logic [`NIC_RPC_DATA_W-1:0] data);
        rpc_t item;
        rpc_in_valid   <= 1'b1;
        rpc_in_flow_id <= flow_id;
        rpc_in_data    <= data;
        credits_used++;
        model_in++;
        if (predict_admit(flow_id, cfg_num_flows, cfg_start)) begin
            item.flow_id = flow_id;
            item.data    = data;
            exp_mem[exp_wr % EXP_SLOTS] = item;
            exp_wr++;
        end else begin
            model_drop++;
        end
    endtask

    // Random gaps, sends only while holding a host credit
    task automatic send_rpcs(input int n, input int lo, input int hi);
        int          sent;
        logic [31:0] pick;
        sent = 0;
        while (sent < n) begin
            @(posedge ccip_clk);
            if (host_credit_count() > 0 && ($urandom % 4) != 0) begin
                pick = 32'(lo) + ($urandom % 32'(hi - lo + 1));
                drive_rpc(pick[`NIC_FLOW_ID_W-1:0], {$urandom, $urandom});
                sent++;
            end else begin
                rpc_in_valid <= 1'b0;
            end
        end
        @(posedge ccip_clk);
        rpc_in_valid <= 1'b0;
    endtask

    // Back to back, ignoring host credits
    task automatic send_without_credit(input int n);
        logic [31:0] pick;
        for (int i = 0; i < n; i++) begin
            @(posedge ccip_clk);
            pick = $urandom % 32'(cfg_num_flows);
            drive_rpc(pick[`NIC_FLOW_ID_W-1:0], {$urandom, $urandom});
        end
        @(posedge ccip_clk);
        rpc_in_valid <= 1'b0;
    endtask

    // Every admitted RPC seen at egress
    task automatic wait_egress();
        while (exp_wr != exp_rd) begin
            @(posedge ccip_clk);
        end
        repeat (2) @(posedge ccip_clk);
    endtask

    // Egress empty and every spent egress credit returned
    task automatic wait_drain();
        wait_egress();
        while (owed_net_credits() != 0) begin
            @(posedge ccip_clk);
        end
        repeat (2) @(posedge ccip_clk);
    endtask

    // ========================================
    // Network model and compare
    // ========================================
    always @(posedge ccip_clk) begin
        if (reset) begin
            net_tx_credit <= 1'b0;
        end else if (net_enable && owed_net_credits() > 0 && ($urandom % 2) == 1) begin
            net_tx_credit <= 1'b1;
            granted_pulses++;
        end else begin
            net_tx_credit <= 1'b0;
        end
    end

    always @(negedge ccip_clk) begin
        if (!reset) begin
            credits_back += int'(rpc_in_credit);
        end
    end

    always @(negedge ccip_clk) begin : compare_egress
        rpc_t want;
        if (!reset && net_tx_valid) begin
            rx_count++;
            if (exp_rd == exp_wr) begin
                err_egress++;
                $display("RPC at egress at %0t that was never admitted", $time);
            end else begin
                want = exp_mem[exp_rd % EXP_SLOTS];
                exp_rd++;
                if (net_tx_flow_id != want.flow_id) begin
                    err_egress++;
                    $display("ERR %0t net_tx_flow_id got %h expected %h",
                             $time, net_tx_flow_id, want.flow_id);
                end
                if (net_tx_data != want.data) begin
                    err_egress++;
                    $display("ERR %0t net_tx_data got %h expected %h",
                             $time, net_tx_data, want.data);
                end
            end
            if (rx_count > `NIC_NET_CREDITS + granted_pulses) begin
                err_egress++;
                $display("Egress sent more RPCs than credits granted at %0t", $time);
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin : main_flow
        int used_before;
        int back_before;
        int rx_before;
        void'($urandom(SEED));
        reset          = 1'b1;
        mmio_wr_valid  = 1'b0;
        mmio_wr_addr   = '0;
        mmio_wr_data   = '0;
        mmio_rd_valid  = 1'b0;
        mmio_rd_addr   = '0;
        mmio_rd_tid    = '0;
        rpc_in_valid   = 1'b0;
        rpc_in_flow_id = '0;
        rpc_in_data    = '0;
        repeat (3) @(posedge ccip_clk);
        reset <= 1'b0;
        @(negedge ccip_clk);
        if (mmio_rsp_valid || net_tx_valid || rpc_in_credit != 2'd0) begin
            err_csr++;
            $display("Control outputs active right after reset");
        end

        // CSR readback
        read_check(NUM_FLOWS, 64'd0, "NUM_FLOWS after reset");
        read_check(START, 64'd0, "START after reset");
        write_csr(NUM_FLOWS, 64'd4);
        write_csr(START, 64'd1);
        write_csr(CNT_SEL, 64'(CNT_DROP));
        read_check(NUM_FLOWS, 64'd4, "NUM_FLOWS");
        read_check(START, 64'd1, "START");
        read_check(CNT_SEL, 64'(CNT_DROP), "CNT_SEL");
        read_check(16'd12, 64'd0, "unmapped 12");
        read_check(16'd3, 64'd0, "unmapped 3");

        // Forwarding
        used_before = credits_used;
        back_before = credits_back;
        send_rpcs(200, 0, 3);
        wait_drain();
        if (credits_back - back_before != credits_used - used_before) begin
            err_egress++;
            $display("Host credits returned differ from RPCs sent while forwarding");
        end

        // Filtering, flows out of range, then stopped
        rx_before   = rx_count;
        used_before = credits_used;
        back_before = credits_back;
        write_csr(NUM_FLOWS, 64'd2);
        send_rpcs(30, 2, 15);
        wait_drain();
        write_csr(START, 64'd0);
        read_check(STATUS, {62'b0, model_error, cfg_start}, "STATUS stopped");
        send_rpcs(20, 0, 15);
        wait_drain();
        if (rx_count != rx_before) begin
            err_egress++;
            $display("Filtered RPCs reached the egress");
        end
        if (credits_back - back_before != credits_used - used_before) begin
            err_egress++;
            $display("Dropped RPCs did not each return a host credit");
        end

        // Back-pressure
        write_csr(START, 64'd1);
        write_csr(NUM_FLOWS, 64'd4);
        net_enable <= 1'b0;
        rx_before   = rx_count;
        back_before = credits_back;
        send_rpcs(12, 0, 3);
        repeat (20) @(posedge ccip_clk);
        if (rx_count - rx_before != `NIC_NET_CREDITS) begin
            err_egress++;
            $display("Blocked egress sent %0d RPCs", rx_count - rx_before);
        end
        // Host credits come back only as entries leave
        if (credits_back - back_before != rx_count - rx_before) begin
            err_egress++;
            $display("Host credits came back for RPCs still held in the FIFO");
        end
        net_enable <= 1'b1;
        wait_drain();

        // Overflow sets the sticky error
        net_enable <= 1'b0;
        send_rpcs(`NIC_NET_CREDITS, 0, 3);
        wait_egress();
        send_without_credit(FIFO_DEPTH + 1);
        // Push into a full FIFO is lost
        if (exp_wr - exp_rd > FIFO_DEPTH) begin
            exp_wr = exp_rd + FIFO_DEPTH;
            model_error = 1'b1;
        end
        repeat (3) @(posedge ccip_clk);
        read_check(STATUS, {62'b0, model_error, cfg_start}, "STATUS overflow");
        net_enable <= 1'b1;
        wait_drain();
        // The lost entry never returns its host credit
        if (host_credit_count() != `NIC_RPC_CREDITS - 1) begin
            err_egress++;
            $display("Host credits after overflow are %0d instead of %0d",
                     host_credit_count(), `NIC_RPC_CREDITS - 1);
        end

        // Counters
        write_csr(CNT_SEL, 64'(CNT_IN));
        read_check(PCK_CNT, 64'(model_in), "incoming count");
        write_csr(CNT_SEL, 64'(CNT_OUT));
        read_check(PCK_CNT, 64'(rx_count), "forwarded count");
        write_csr(CNT_SEL, 64'(CNT_DROP));
        read_check(PCK_CNT, 64'(model_drop), "dropped count");

        $display("Errors: csr %0d, egress %0d", err_csr, err_egress);
        if (err_csr == 0 && err_egress == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge ccip_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the sequence did not complete", cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* dv/nic_checker.sv */
// ========================================
// NIC credit FIFO checker
// Egress credit rules and reset behavior,
// bound to every rpc_credit_fifo
// ========================================

`timescale 1ns/1ns

`include "nic_config.svh"

module nic_checker (
    input logic                                     ccip_clk,
    input logic                                     reset,
    input logic                                     net_tx_valid,
    input logic [$clog2(`NIC_NET_CREDITS + 1)-1:0] net_credits
);

    localparam int CRD_W = $clog2(`NIC_NET_CREDITS + 1);
    localparam logic [CRD_W-1:0] MAX_CREDITS = CRD_W'(`NIC_NET_CREDITS);

    // Nothing leaves without an egress credit
    no_tx_without_credit: assert property (
        @(posedge ccip_clk) disable iff (reset) (net_credits == '0) |=> !net_tx_valid
    ) else $error("Egress sent with zero egress credits");

    credit_bound: assert property (
        @(posedge ccip_clk) disable iff (reset) net_credits <= MAX_CREDITS
    ) else $error("Egress credit count above its initial value");

    tx_idle_after_reset: assert property (
        @(posedge ccip_clk) reset |=> !net_tx_valid
    ) else $error("net_tx_valid high in the cycle after reset");

endmodule

bind rpc_credit_fifo nic_checker checker_i (
    .ccip_clk     (ccip_clk),
    .reset        (reset),
    .net_tx_valid (net_tx_valid),
    .net_credits  (net_credits)
);

/* source/nic_top.sv */
// ========================================
// NIC top level
// CSR block, RPC filter, credit FIFO and
// statistics on a single ccip_clk
// ========================================

`timescale 1ns/1ns

`include "nic_config.svh"

module nic_top (
    input  logic                        ccip_clk,
    input  logic                        reset,
    // MMIO
    input  logic                        mmio_wr_valid,
    input  logic [`NIC_MMIO_ADDR_W-1:0] mmio_wr_addr,
    input  logic [63:0]                 mmio_wr_data,
    input  logic                        mmio_rd_valid,
    input  logic [`NIC_MMIO_ADDR_W-1:0] mmio_rd_addr,
    input  logic [8:0]                  mmio_rd_tid,
    output logic                        mmio_rsp_valid,
    output logic [8:0]                  mmio_rsp_tid,
    output logic [63:0]                 mmio_rsp_data,
    // RPC ingress
    input  logic                        rpc_in_valid,
    input  logic [`NIC_FLOW_ID_W-1:0]   rpc_in_flow_id,
    input  logic [`NIC_RPC_DATA_W-1:0]  rpc_in_data,
    output logic [1:0]                  rpc_in_credit,
    // Network egress
    output logic                        net_tx_valid,
    output logic [`NIC_FLOW_ID_W-1:0]   net_tx_flow_id,
    output logic [`NIC_RPC_DATA_W-1:0]  net_tx_data,
    input  logic                        net_tx_credit
);

    import nic_pkg::*;

    logic [`NIC_FLOW_ID_W:0] num_flows;
    logic                    nic_start;
    cnt_sel_e                cnt_sel;
    logic                    admit_pulse;
    logic                    drop_pulse;
    logic [`NIC_CNT_W-1:0]   pck_cnt_value;
    logic [`NIC_CNT_W-1:0]   rps_value;

    rpc_channel_if chan_i ();

    nic_csr csr_i (
        .ccip_clk       (ccip_clk),
        .reset          (reset),
        .mmio_wr_valid  (mmio_wr_valid),
        .mmio_wr_addr   (mmio_wr_addr),
        .mmio_wr_data   (mmio_wr_data),
        .mmio_rd_valid  (mmio_rd_valid),
        .mmio_rd_addr   (mmio_rd_addr),
        .mmio_rd_tid    (mmio_rd_tid),
        .fifo_overflow  (chan_i.overflow),
        .pck_cnt_value  (pck_cnt_value),
        .rps_value      (rps_value),
        .mmio_rsp_valid (mmio_rsp_valid),
        .mmio_rsp_tid   (mmio_rsp_tid),
        .mmio_rsp_data  (mmio_rsp_data),
        .num_flows      (num_flows),
        .nic_start      (nic_start),
        .cnt_sel        (cnt_sel)
    );

    rpc_flow_filter filter_i (
        .ccip_clk       (ccip_clk),
        .reset          (reset),
        .rpc_in_valid   (rpc_in_valid),
        .rpc_in_flow_id (rpc_in_flow_id),
        .rpc_in_data    (rpc_in_data),
        .num_flows      (num_flows),
        .nic_start      (nic_start),
        .rpc_in_credit  (rpc_in_credit),
        .drop_pulse     (drop_pulse),
        .admit_pulse    (admit_pulse),
        .chan           (chan_i.src)
    );

    rpc_credit_fifo fifo_i (
        .ccip_clk       (ccip_clk),
        .reset          (reset),
        .net_tx_credit  (net_tx_credit),
        .net_tx_valid   (net_tx_valid),
        .net_tx_flow_id (net_tx_flow_id),
        .net_tx_data    (net_tx_data),
        .chan           (chan_i.dst)
    );

    nic_counters counters_i (
        .ccip_clk      (ccip_clk),
        .reset         (reset),
        .admit_pulse   (admit_pulse),
        .drop_pulse    (drop_pulse),
        .net_tx_valid  (net_tx_valid),
        .cnt_sel       (cnt_sel),
        .pck_cnt_value (pck_cnt_value),
        .rps_value     (rps_value)
    );

endmodule

/* source/nic_counters.sv */
// ========================================
// NIC statistics
// Incoming, forwarded and dropped counts,
// plus admitted requests per rate window
// ========================================

`timescale 1ns/1ns

`include "nic_config.svh"

module nic_counters (
    input  logic                  ccip_clk,
    input  logic                  reset,
    input  logic                  admit_pulse,
    input  logic                  drop_pulse,
    input  logic                  net_tx_valid,
    input  nic_pkg::cnt_sel_e     cnt_sel,
    output logic [`NIC_CNT_W-1:0] pck_cnt_value,
    output logic [`NIC_CNT_W-1:0] rps_value
);

    import nic_pkg::*;

    localparam int WIN_W = $clog2(`NIC_RATE_WINDOW);

    logic [`NIC_CNT_W-1:0] cnt_in;
    logic [`NIC_CNT_W-1:0] cnt_out;
    logic [`NIC_CNT_W-1:0] cnt_drop;
    logic [`NIC_CNT_W-1:0] rate_cnt;
    logic [WIN_W-1:0]      window_cnt;

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            cnt_in     <= '0;
            cnt_out    <= '0;
            cnt_drop   <= '0;
            rate_cnt   <= '0;
            window_cnt <= '0;
            rps_value  <= '0;
        end else begin
            if (admit_pulse || drop_pulse) begin
                cnt_in <= cnt_in + 1'b1;
            end
            if (net_tx_valid) begin
                cnt_out <= cnt_out + 1'b1;
            end
            if (drop_pulse) begin
                cnt_drop <= cnt_drop + 1'b1;
            end
            // Window end, last-cycle admit still counts
            if (window_cnt == WIN_W'(`NIC_RATE_WINDOW - 1)) begin
                rps_value  <= rate_cnt + `NIC_CNT_W'(admit_pulse);
                rate_cnt   <= '0;
                window_cnt <= '0;
            end else begin
                rate_cnt   <= rate_cnt + `NIC_CNT_W'(admit_pulse);
                window_cnt <= window_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (cnt_sel)
            CNT_IN:   pck_cnt_value = cnt_in;
            CNT_OUT:  pck_cnt_value = cnt_out;
            CNT_DROP: pck_cnt_value = cnt_drop;
            default:  pck_cnt_value = '0;
        endcase
    end

endmodule

/* rpc/rpc_credit_fifo.sv */
// ========================================
// RPC credit FIFO
// Holds admitted RPCs and sends them to
// the network against egress credits
// ========================================

`timescale 1ns/1ns

`include "nic_config.svh"

module rpc_credit_fifo (
    input  logic                       ccip_clk,
    input  logic                       reset,
    input  logic                       net_tx_credit,
    output logic                       net_tx_valid,
    output logic [`NIC_FLOW_ID_W-1:0]  net_tx_flow_id,
    output logic [`NIC_RPC_DATA_W-1:0] net_tx_data,
    rpc_channel_if.dst                 chan
);

    import nic_pkg::*;

    localparam int LDEPTH = `NIC_RPC_FIFO_LDEPTH;
    localparam int DEPTH  = 1 << LDEPTH;
    localparam int CRD_W  = $clog2(`NIC_NET_CREDITS + 1);

    rpc_t              mem [DEPTH];
    logic [LDEPTH-1:0] wr_ptr;
    logic [LDEPTH-1:0] rd_ptr;
    logic [LDEPTH:0]   count;
    logic [CRD_W-1:0]  net_credits;
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;

    assign full  = (count == (LDEPTH + 1)'(DEPTH));
    assign empty = (count == '0);
    assign pop   = !empty && (net_credits != '0);
    // A full FIFO still takes a push when it pops in the same cycle
    assign push  = chan.valid && (!full || pop);

    always_ff @(posedge ccip_clk) begin
        if (push) begin
            mem[wr_ptr] <= chan.rpc;
        end
        if (pop) begin
            net_tx_flow_id <= mem[rd_ptr].flow_id;
            net_tx_data    <= mem[rd_ptr].data;
        end
    end

    // ========================================
    // Pointers, credits and pulses
    // ========================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            net_credits   <= CRD_W'(`NIC_NET_CREDITS);
            net_tx_valid  <= 1'b0;
            chan.credit   <= 1'b0;
            chan.overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Returned credit and pop cancel out
            case ({net_tx_credit, pop})
                2'b10:   net_credits <= net_credits + 1'b1;
                2'b01:   net_credits <= net_credits - 1'b1;
                default: net_credits <= net_credits;
            endcase
            net_tx_valid  <= pop;
            chan.credit   <= pop;
            chan.overflow <= chan.valid && !push;
        end
    end

endmodule

/* rpc/rpc_flow_filter.sv */
// ========================================
// RPC flow filter
// Admits RPCs for configured flows while
// running, drops the rest with a credit
// ========================================

`timescale 1ns/1ns

`include "nic_config.svh"

module rpc_flow_filter (
    input  logic                       ccip_clk,
    input  logic                       reset,
    input  logic                       rpc_in_valid,
    input  logic [`NIC_FLOW_ID_W-1:0]  rpc_in_flow_id,
    input  logic [`NIC_RPC_DATA_W-1:0] rpc_in_data,
    input  logic [`NIC_FLOW_ID_W:0]    num_flows,
    input  logic                       nic_start,
    output logic [1:0]                 rpc_in_credit,
    output logic                       drop_pulse,
    output logic                       admit_pulse,
    rpc_channel_if.src                 chan
);

    logic admit;
    logic drop_q;

    // Flow id compared against the count, one bit wider
    assign admit = nic_start && ({1'b0, rpc_in_flow_id} < num_flows);

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            chan.valid <= 1'b0;
            drop_q     <= 1'b0;
        end else begin
            chan.valid <= rpc_in_valid && admit;
            drop_q     <= rpc_in_valid && !admit;
        end
    end

    always_ff @(posedge ccip_clk) begin
        chan.rpc.flow_id <= rpc_in_flow_id;
        chan.rpc.data    <= rpc_in_data;
    end

    assign admit_pulse = chan.valid;
    assign drop_pulse  = drop_q;

    // Drop credit and FIFO credit can land in the same cycle
    assign rpc_in_credit = {1'b0, drop_q} + {1'b0, chan.credit};

endmodule

/* csr/nic_csr.sv */
// ========================================
// NIC CSR block
// MMIO write decode, config registers,
// status register and registered read mux
// ========================================

`timescale 1ns/1ns

`include "nic_config.svh"

module nic_csr (
    input  logic                        ccip_clk,
    input  logic                        reset,
    input  logic                        mmio_wr_valid,
    input  logic [`NIC_MMIO_ADDR_W-1:0] mmio_wr_addr,
    input  logic [63:0]                 mmio_wr_data,
    input  logic                        mmio_rd_valid,
    input  logic [`NIC_MMIO_ADDR_W-1:0] mmio_rd_addr,
    input  logic [8:0]                  mmio_rd_tid,
    input  logic                        fifo_overflow,
    input  logic [`NIC_CNT_W-1:0]       pck_cnt_value,
    input  logic [`NIC_CNT_W-1:0]       rps_value,
    output logic                        mmio_rsp_valid,
    output logic [8:0]                  mmio_rsp_tid,
    output logic [63:0]                 mmio_rsp_data,
    output logic [`NIC_FLOW_ID_W:0]     num_flows,
    output logic                        nic_start,
    output nic_pkg::cnt_sel_e           cnt_sel
);

    import nic_pkg::*;

    logic        error_q;
    nic_status_t status;

    // ========================================
    // Write side
    // ========================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            num_flows <= '0;
            nic_start <= 1'b0;
            cnt_sel   <= CNT_IN;
        end else if (mmio_wr_valid) begin
            case (mmio_wr_addr)
                NUM_FLOWS: num_flows <= mmio_wr_data[`NIC_FLOW_ID_W:0];
                START:     nic_start <= mmio_wr_data[0];
                CNT_SEL:   cnt_sel   <= cnt_sel_e'(mmio_wr_data[1:0]);
                default: ;
            endcase
        end
    end

    // Sticky error, only reset clears it
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            error_q <= 1'b0;
        end else if (fifo_overflow) begin
            error_q <= 1'b1;
        end
    end

    assign status.running = nic_start;
    assign status.error   = error_q;

    // ========================================
    // Read side
    // ========================================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            mmio_rsp_valid <= 1'b0;
        end else begin
            mmio_rsp_valid <= mmio_rd_valid;
        end
    end

    // Tid echo, unmapped reads give zero
    always_ff @(posedge ccip_clk) begin
        mmio_rsp_tid <= mmio_rd_tid;
        case (mmio_rd_addr)
            NUM_FLOWS: mmio_rsp_data <= 64'(num_flows);
            START:     mmio_rsp_data <= {63'b0, nic_start};
            STATUS:    mmio_rsp_data <= 64'(status);
            CNT_SEL:   mmio_rsp_data <= 64'(cnt_sel);
            PCK_CNT:   mmio_rsp_data <= 64'(pck_cnt_value);
            RPS:       mmio_rsp_data <= 64'(rps_value);
            default:   mmio_rsp_data <= 64'b0;
        endcase
    end

endmodule

/* common/rpc_channel_if.sv */
// ========================================
// RPC channel
// Admitted RPCs from filter to FIFO, with
// credit return and overflow back
// ========================================

`timescale 1ns/1ns

interface rpc_channel_if;

    import nic_pkg::*;

    logic valid;
    rpc_t rpc;
    // One pulse per entry leaving the FIFO
    logic credit;
    // Push into a full FIFO, entry lost
    logic overflow;

    modport src (
        output valid,
        output rpc,
        input  credit
    );

    modport dst (
        input  valid,
        input  rpc,
        output credit,
        output overflow
    );

endinterface

/* common/nic_pkg.sv */
// ========================================
// NIC shared types
// CSR address map, counter select, RPC
// payload and status register layout
// ========================================

package nic_pkg;

`include "nic_config.svh"

    // ========================================
    // CSR map
    // ========================================
    // Word addresses of 64-bit registers, so steps of 2
    typedef enum logic [`NIC_MMIO_ADDR_W-1:0] {
        NUM_FLOWS = 16'd0,
        START     = 16'd2,
        STATUS    = 16'd4,
        CNT_SEL   = 16'd6,
        PCK_CNT   = 16'd8,
        RPS       = 16'd10
    } csr_addr_e;

    // Counter shown through PCK_CNT
    typedef enum logic [1:0] {
        CNT_IN   = 2'd0,
        CNT_OUT  = 2'd1,
        CNT_DROP = 2'd2
    } cnt_sel_e;

    // ========================================
    // Payload and status
    // ========================================
    typedef struct packed {
        logic [`NIC_FLOW_ID_W-1:0]  flow_id;
        logic [`NIC_RPC_DATA_W-1:0] data;
    } rpc_t;

    // Error in bit 1, running in bit 0
    typedef struct packed {
        logic error;
        logic running;
    } nic_status_t;

endpackage

/* common/nic_config.svh */
// ========================================
// NIC configuration
// Widths, FIFO depth, credit counts and
// the request-rate window
// ========================================

`ifndef NIC_CONFIG_SVH
`define NIC_CONFIG_SVH

// Datapath widths
`define NIC_FLOW_ID_W       4
`define NIC_RPC_DATA_W      64
`define NIC_CNT_W           32
`define NIC_MMIO_ADDR_W     16

// RPC FIFO, depth is 2**LDEPTH
`define NIC_RPC_FIFO_LDEPTH 3

// Initial credits, host side matches the FIFO depth
`define NIC_RPC_CREDITS     8
`define NIC_NET_CREDITS     4

// Rate window in ccip_clk cycles
`define NIC_RATE_WINDOW     64

`endif
